/* bench/tb_cpu_top.sv */
`default_nettype none

module tb_cpu_top import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    MAX_CYC    = 600;
  localparam int    N_TESTS    = 6;
  localparam int    HALT_WAIT  = 20;
  localparam addr_t VECTOR     = 16'h1000;
  localparam addr_t JMP_TARGET = 16'h2400;

  logic  clk = 1'b0;
  logic  resetn;
  addr_t address;
  byte_t rd_data;
  byte_t wr_data;
  logic  wr_enable;

  // Expected bus activity, indexed by cycles since reset release
  logic  exp_av   [MAX_CYC];
  addr_t exp_a    [MAX_CYC];
  logic  exp_we   [MAX_CYC];
  byte_t exp_wd   [MAX_CYC];
  logic  exp_hold [MAX_CYC];
  int    test_of  [MAX_CYC];
  int    test_last [N_TESTS+1];
  int    errs      [N_TESTS+1];
  string test_name [N_TESTS+1];

  int    cyc;
  int    n_cyc;
  int    n_stores;
  int    total_err;
  logic  built;
  addr_t last_addr;

  // Program builder state and reference registers
  addr_t pc;
  addr_t data_ptr;
  addr_t store_ptr;
  int    cur_test;
  byte_t ra;
  byte_t rx;
  byte_t ry;
  logic  rc;

  cpu_top u_dut (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable)
  );

  tb_memory u_mem (
    .clk       (clk),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .rd_data   (rd_data)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!resetn) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // --------------------------------------------------
  // Program builder and reference model
  // --------------------------------------------------
  function automatic byte_t rand_byte();
    return 8'($urandom);
  endfunction

  task automatic advance(int n);
    for (int i = 0; i < n; i++) begin
      test_of[n_cyc + i] = cur_test;
    end
    n_cyc = n_cyc + n;
    test_last[cur_test] = n_cyc - 1;
  endtask

  task automatic expect_addr(int c, addr_t a);
    exp_av[c] = 1'b1;
    exp_a[c]  = a;
  endtask

  task automatic emit(byte_t b);
    u_mem.load_byte(pc, b);
    pc = pc + 16'd1;
  endtask

  task automatic do_imp(byte_t opc);
    expect_addr(n_cyc, pc);
    emit(opc);
    case (opc)
      CLC_IMP: rc = 1'b0;
      SEC_IMP: rc = 1'b1;
      ASL_ACC: begin
        rc = ra[7];
        ra = {ra[6:0], 1'b0};
      end
      LSR_ACC: begin
        rc = ra[0];
        ra = {1'b0, ra[7:1]};
      end
      default: ;
    endcase
    advance(2);
  endtask

  task automatic do_imm(byte_t opc, byte_t val);
    expect_addr(n_cyc, pc);
    emit(opc);
    emit(val);
    case (opc)
      LDA_IMM: ra = val;
      LDX_IMM: rx = val;
      default: ry = val;
    endcase
    advance(2);
  endtask

  // Stores go to fresh addresses, operands come from the data area
  task automatic do_abs(byte_t opc, byte_t val);
    addr_t ea;
    int    total;
    expect_addr(n_cyc, pc);
    if (opc == STA_ABS || opc == STX_ABS || opc == STY_ABS) begin
      ea = store_ptr;
      store_ptr = store_ptr + 16'd1;
      expect_addr(n_cyc + 3, ea);
      exp_we[n_cyc + 3] = 1'b1;
      exp_wd[n_cyc + 3] = (opc == STX_ABS) ? rx : (opc == STY_ABS) ? ry : ra;
      n_stores = n_stores + 1;
    end else begin
      ea = data_ptr;
      data_ptr = data_ptr + 16'd1;
      u_mem.load_byte(ea, val);
    end
    emit(opc);
    emit(ea[7:0]);
    emit(ea[15:8]);
    case (opc)
      LDA_ABS: ra = val;
      LDX_ABS: rx = val;
      LDY_ABS: ry = val;
      ADC_ABS: begin
        total = int'(ra) + int'(val) + int'(rc);
        ra = 8'(total);
        rc = (total > 255);
      end
      AND_ABS: ra = ra & val;
      ORA_ABS: ra = ra | val;
      EOR_ABS: ra = ra ^ val;
      default: ;
    endcase
    advance(4);
  endtask

  task automatic do_jmp(addr_t target);
    expect_addr(n_cyc, pc);
    emit(JMP_ABS);
    emit(target[7:0]);
    emit(target[15:8]);
    pc = target;
    advance(3);
  endtask

  // Undecoded opcode, then the bus must freeze
  task automatic do_halt();
    expect_addr(n_cyc, pc);
    emit(8'h02);
    for (int i = 3; i < HALT_WAIT; i++) begin
      exp_hold[n_cyc + i] = 1'b1;
    end
    advance(HALT_WAIT);
  endtask

  task automatic build_program();
    for (int i = 0; i < MAX_CYC; i++) begin
      exp_av[i]   = 1'b0;
      exp_a[i]    = '0;
      exp_we[i]   = 1'b0;
      exp_wd[i]   = '0;
      exp_hold[i] = 1'b0;
      test_of[i]  = 0;
    end
    pc        = VECTOR;
    data_ptr  = 16'h0200;
    store_ptr = 16'h0300;
    ra        = '0;
    rx        = '0;
    ry        = '0;
    rc        = 1'b0;
    n_cyc     = 0;
    n_stores  = 0;
    u_mem.fill_pattern();
    u_mem.load_byte(RESET_VEC_LO, VECTOR[7:0]);
    u_mem.load_byte(RESET_VEC_HI, VECTOR[15:8]);

    cur_test = 1;
    expect_addr(0, RESET_VEC_LO);
    expect_addr(1, RESET_VEC_HI);
    expect_addr(2, VECTOR);
    advance(3);
    do_imp(NOP_IMP);

    cur_test = 2;
    do_imm(LDA_IMM, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_imm(LDX_IMM, rand_byte());
    do_abs(STX_ABS, 8'h00);
    do_imm(LDY_IMM, rand_byte());
    do_abs(STY_ABS, 8'h00);
    do_abs(LDA_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_abs(LDX_ABS, rand_byte());
    do_abs(STX_ABS, 8'h00);
    do_abs(LDY_ABS, rand_byte());
    do_abs(STY_ABS, 8'h00);

    cur_test = 3;
    do_imp(CLC_IMP);
    // Both top bits set, so the first sum always carries out
    do_imm(LDA_IMM, rand_byte() | 8'h80);
    do_abs(ADC_ABS, rand_byte() | 8'h80);
    do_abs(STA_ABS, 8'h00);
    do_abs(ADC_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_imp(SEC_IMP);
    do_imm(LDA_IMM, rand_byte());
    do_abs(ADC_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_imm(LDA_IMM, rand_byte());
    do_abs(AND_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_abs(ORA_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);
    do_abs(EOR_ABS, rand_byte());
    do_abs(STA_ABS, 8'h00);

    cur_test = 4;
    // Carry starts clear, each shift pushes out a one
    do_imp(CLC_IMP);
    do_imm(LDA_IMM, rand_byte() | 8'h80);
    do_imp(ASL_ACC);
    do_abs(STA_ABS, 8'h00);
    do_imm(LDA_IMM, 8'h00);
    do_abs(ADC_ABS, 8'h00);
    do_abs(STA_ABS, 8'h00);
    do_imm(LDA_IMM, rand_byte() | 8'h01);
    do_imp(LSR_ACC);
    do_abs(STA_ABS, 8'h00);
    do_imm(LDA_IMM, 8'h00);
    do_abs(ADC_ABS, 8'h00);
    do_abs(STA_ABS, 8'h00);

    cur_test = 5;
    do_imp(NOP_IMP);
    do_jmp(JMP_TARGET);
    do_imp(NOP_IMP);
    do_imp(NOP_IMP);
    do_imm(LDA_IMM, rand_byte());
    do_abs(STA_ABS, 8'h00);

    cur_test = 6;
    do_halt();
  endtask

  // --------------------------------------------------
  // Checks, sampled mid-cycle where outputs are stable
  // --------------------------------------------------
  task automatic flag(string name, logic [15:0] got, logic [15:0] want);
    int idx;
    idx = (resetn && cyc < MAX_CYC) ? test_of[cyc] : 0;
    $display("CHECK FAILED %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, want, cyc);
    errs[idx]++;
    total_err++;
  endtask

  always @(negedge clk) begin
    if (!resetn) begin
      assert (address == RESET_VEC_LO) else flag("address", address, RESET_VEC_LO);
      assert (wr_enable == 1'b0) else flag("wr_enable", 16'(wr_enable), 16'h0);
    end else if (cyc < MAX_CYC) begin
      assert (wr_enable == exp_we[cyc])
        else flag("wr_enable", 16'(wr_enable), 16'(exp_we[cyc]));
      if (exp_av[cyc]) begin
        assert (address == exp_a[cyc]) else flag("address", address, exp_a[cyc]);
      end
      if (exp_we[cyc]) begin
        assert (wr_data == exp_wd[cyc])
          else flag("wr_data", 16'(wr_data), 16'(exp_wd[cyc]));
      end
      if (exp_hold[cyc]) begin
        assert (address == last_addr) else flag("address", address, last_addr);
      end
    end
    last_addr = address;
  end

  // Watchdog, program length plus a margin
  initial begin
    wait (built);
    #((n_cyc + 3 + 40) * 20);
    $display("Timeout: the program did not finish within %0d cycles", n_cyc + 40);
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence and report
  // --------------------------------------------------
  initial begin
    int failed;
    resetn    = 1'b0;
    built     = 1'b0;
    total_err = 0;
    failed    = 0;
    last_addr = '0;
    for (int t = 0; t <= N_TESTS; t++) begin
      errs[t]      = 0;
      test_last[t] = 0;
    end
    test_name[1] = "reset vector";
    test_name[2] = "loads/stores";
    test_name[3] = "alu/carry";
    test_name[4] = "acc shifts";
    test_name[5] = "jump";
    test_name[6] = "halt";
    void'($urandom(30185));
    build_program();
    built = 1'b1;

    repeat (3) @(posedge clk);
    #2 resetn = 1'b1;

    for (int t = 1; t <= N_TESTS; t++) begin
      while (cyc <= test_last[t]) begin
        @(posedge clk);
        #1;
      end
      if (errs[t] != 0) begin
        failed++;
      end
      $display("test %0d %-14s %s (%0d errors)", t, test_name[t],
               (errs[t] == 0) ? "ok" : "fail", errs[t]);
    end

    assert (u_mem.write_count == n_stores)
      else flag("write_count", 16'(u_mem.write_count), 16'(n_stores));
    $display("summary: %0d tests, %0d failed, %0d check errors, %0d reset errors",
             N_TESTS, failed, total_err, errs[0]);
    if (total_err == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/tb_memory.sv */
`default_nettype none

module tb_memory import cpu_pkg::*; (
  input  wire        clk,
  input  wire addr_t address,
  input  wire byte_t wr_data,
  input  wire        wr_enable,
  output byte_t      rd_data
);

  timeunit 1ns;
  timeprecision 100ps;

  byte_t mem [0:65535];
  int    write_count;

  // Memory answers in the same cycle
  assign rd_data = mem[address];

  // --------------------------------------------------
  // Image loader
  // --------------------------------------------------
  task automatic fill_pattern();
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
    end
    write_count = 0;
  endtask

  task automatic load_byte(addr_t a, byte_t d);
    mem[a] = d;
  endtask

  // Write monitor, counts every store the CPU makes
  always @(posedge clk) begin
    if (wr_enable) begin
      mem[address] = wr_data;
      write_count = write_count + 1;
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu_top \
  -f verilog.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^\*\*\* PASSED \*\*\*$'; then
  exit 0
fi
exit 1

/* src/bus_master.sv */
`default_nettype none

module bus_master import cpu_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire byte_t rd_data,
  input  wire byte_t store_data,
  instr_if.dst       instr,
  seq_if.obs         seq,
  output addr_t      address,
  output byte_t      wr_data,
  output logic       wr_enable
);

  addr_t addr_nxt;

  // --------------------------------------------------
  // Address for the following bus cycle
  // --------------------------------------------------
  always_comb begin
    case (seq.state)
      ST_RESET: addr_nxt = RESET_VEC_HI;
      // High operand byte is on rd_data, so the data address is complete
      ST_ABS_1: begin
        if (instr.mode == MODE_ABS) begin
          addr_nxt = {rd_data, instr.operand_lo};
        end else begin
          addr_nxt = seq.next_pc;
        end
      end
      ST_HALT:  addr_nxt = address;
      default:  addr_nxt = seq.next_pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      address   <= RESET_VEC_LO;
      wr_enable <= 1'b0;
    end else begin
      address   <= addr_nxt;
      wr_enable <= seq.wr_req;
    end
  end

  // Store data, held until the next store
  always_ff @(posedge clk) begin
    if (seq.wr_req) begin
      wr_data <= store_data;
    end
  end

endmodule

`default_nettype wire

/* src/cpu_ifs.sv */
`default_nettype none

// --------------------------------------------------
// Decoded instruction, from the latch to the core
// --------------------------------------------------
interface instr_if import cpu_pkg::*; ();

  byte_t      ir;
  addr_mode_t mode;
  op_t        op;
  byte_t      operand_lo;

  modport src (
    output ir,
    output mode,
    output op,
    output operand_lo
  );

  modport dst (
    input ir,
    input mode,
    input op,
    input operand_lo
  );

endinterface

// --------------------------------------------------
// Sequencer state and bus requests
// --------------------------------------------------
interface seq_if import cpu_pkg::*; ();

  cpu_state_t state;
  addr_t      next_pc;
  logic       wr_req;
  logic       commit;

  modport ctl (
    output state,
    output next_pc,
    output wr_req,
    output commit
  );

  modport obs (
    input state,
    input next_pc,
    input wr_req,
    input commit
  );

endinterface

`default_nettype wire

/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // --------------------------------------------------
  // Widths and bus types
  // --------------------------------------------------
  localparam int BYTE_W = 8;
  localparam int ADDR_W = 16;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Reset vector location in memory
  localparam addr_t RESET_VEC_LO = 16'hFFFC;
  localparam addr_t RESET_VEC_HI = 16'hFFFD;

  // --------------------------------------------------
  // Opcodes of the supported subset
  // --------------------------------------------------
  localparam byte_t LDA_IMM = 8'hA9;
  localparam byte_t LDX_IMM = 8'hA2;
  localparam byte_t LDY_IMM = 8'hA0;
  localparam byte_t LDA_ABS = 8'hAD;
  localparam byte_t LDX_ABS = 8'hAE;
  localparam byte_t LDY_ABS = 8'hAC;
  localparam byte_t STA_ABS = 8'h8D;
  localparam byte_t STX_ABS = 8'h8E;
  localparam byte_t STY_ABS = 8'h8C;
  localparam byte_t ADC_ABS = 8'h6D;
  localparam byte_t AND_ABS = 8'h2D;
  localparam byte_t ORA_ABS = 8'h0D;
  localparam byte_t EOR_ABS = 8'h4D;
  localparam byte_t ASL_ACC = 8'h0A;
  localparam byte_t LSR_ACC = 8'h4A;
  localparam byte_t JMP_ABS = 8'h4C;
  localparam byte_t NOP_IMP = 8'hEA;
  localparam byte_t CLC_IMP = 8'h18;
  localparam byte_t SEC_IMP = 8'h38;

  // Addressing class, picks the path through the FSM
  typedef enum logic [2:0] {
    MODE_IMP,
    MODE_IMM,
    MODE_ABS,
    MODE_JMP,
    MODE_BAD
  } addr_mode_t;

  typedef enum logic [3:0] {
    OP_NOP,
    OP_LDA,
    OP_LDX,
    OP_LDY,
    OP_STA,
    OP_STX,
    OP_STY,
    OP_ADC,
    OP_AND,
    OP_ORA,
    OP_EOR,
    OP_ASL,
    OP_LSR,
    OP_CLC,
    OP_SEC,
    OP_JMP
  } op_t;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_VECTOR_1,
    ST_VECTOR_2,
    ST_FETCH,
    ST_DECODE,
    ST_ABS_1,
    ST_ABS_2,
    ST_HALT
  } cpu_state_t;

endpackage

`default_nettype wire

/* src/cpu_top.sv */
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire byte_t rd_data,
  output addr_t      address,
  output byte_t      wr_data,
  output logic       wr_enable
);

  byte_t store_data;

  instr_if instr ();
  seq_if   seq ();

  instr_latch u_instr_latch (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .seq     (seq),
    .instr   (instr)
  );

  cycle_sequencer u_cycle_sequencer (
    .clk     (clk),
    .resetn  (resetn),
    .rd_data (rd_data),
    .instr   (instr),
    .seq     (seq)
  );

  exec_unit u_exec_unit (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .instr      (instr),
    .seq        (seq),
    .store_data (store_data)
  );

  bus_master u_bus_master (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .store_data (store_data),
    .instr      (instr),
    .seq        (seq),
    .address    (address),
    .wr_data    (wr_data),
    .wr_enable  (wr_enable)
  );

endmodule

`default_nettype wire

/* src/cycle_sequencer.sv */
`default_nettype none

module cycle_sequencer import cpu_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire byte_t rd_data,
  instr_if.dst       instr,
  seq_if.ctl         seq
);

  cpu_state_t state;
  cpu_state_t state_nxt;
  addr_t      pc;
  addr_t      next_pc;
  logic       pc_load;
  logic       writes_reg;
  logic       is_store;

  // --------------------------------------------------
  // State register and next state
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    case (state)
      ST_RESET:    state_nxt = ST_VECTOR_1;
      ST_VECTOR_1: state_nxt = ST_VECTOR_2;
      ST_VECTOR_2: state_nxt = ST_FETCH;
      ST_FETCH:    state_nxt = ST_DECODE;
      ST_DECODE: begin
        case (instr.mode)
          MODE_IMP, MODE_IMM: state_nxt = ST_FETCH;
          MODE_ABS, MODE_JMP: state_nxt = ST_ABS_1;
          default:            state_nxt = ST_HALT;
        endcase
      end
      // JMP is done once the high operand byte is known
      ST_ABS_1:    state_nxt = (instr.mode == MODE_JMP) ? ST_FETCH : ST_ABS_2;
      ST_ABS_2:    state_nxt = ST_FETCH;
      default:     state_nxt = ST_HALT;
    endcase
  end

  // --------------------------------------------------
  // Program counter
  // --------------------------------------------------
  // pc holds the opcode address of the current instruction
  always_comb begin
    next_pc = pc;
    pc_load = 1'b0;
    case (state)
      ST_VECTOR_1: begin
        next_pc = {rd_data, pc[7:0]};
        pc_load = 1'b1;
      end
      ST_FETCH: next_pc = pc + 16'd1;
      ST_DECODE: begin
        case (instr.mode)
          MODE_IMP: begin
            next_pc = pc + 16'd1;
            pc_load = 1'b1;
          end
          MODE_IMM: begin
            next_pc = pc + 16'd2;
            pc_load = 1'b1;
          end
          MODE_ABS, MODE_JMP: next_pc = pc + 16'd2;
          default: next_pc = pc;
        endcase
      end
      ST_ABS_1: begin
        if (instr.mode == MODE_JMP) begin
          next_pc = {rd_data, instr.operand_lo};
          pc_load = 1'b1;
        end
      end
      ST_ABS_2: begin
        next_pc = pc + 16'd3;
        pc_load = 1'b1;
      end
      default: next_pc = pc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pc <= '0;
    end else if (state == ST_RESET) begin
      pc[7:0] <= rd_data;
    end else if (pc_load) begin
      pc <= next_pc;
    end
  end

  // --------------------------------------------------
  // Requests to the datapath and bus side
  // --------------------------------------------------
  always_comb begin
    case (instr.op)
      OP_NOP, OP_STA, OP_STX, OP_STY, OP_JMP: writes_reg = 1'b0;
      default:                                writes_reg = 1'b1;
    endcase
  end

  assign is_store = (instr.op == OP_STA) || (instr.op == OP_STX) || (instr.op == OP_STY);

  assign seq.state   = state;
  assign seq.next_pc = next_pc;
  assign seq.wr_req  = (state == ST_ABS_1) && is_store;
  // Short instructions finish in decode, absolute ones in ABS_2
  assign seq.commit  = writes_reg &&
                       (((state == ST_DECODE) &&
                         ((instr.mode == MODE_IMP) || (instr.mode == MODE_IMM))) ||
                        (state == ST_ABS_2));

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`default_nettype none

module exec_unit import cpu_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire byte_t rd_data,
  instr_if.dst       instr,
  seq_if.obs         seq,
  output byte_t      store_data
);

  byte_t           a;
  byte_t           x;
  byte_t           y;
  logic            c;
  byte_t           a_nxt;
  byte_t           x_nxt;
  byte_t           y_nxt;
  logic            c_nxt;
  logic [BYTE_W:0] sum;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  assign sum = {1'b0, a} + {1'b0, rd_data} + {{BYTE_W{1'b0}}, c};

  always_comb begin
    a_nxt = a;
    x_nxt = x;
    y_nxt = y;
    c_nxt = c;
    case (instr.op)
      OP_LDA: a_nxt = rd_data;
      OP_LDX: x_nxt = rd_data;
      OP_LDY: y_nxt = rd_data;
      OP_ADC: {c_nxt, a_nxt} = sum;
      OP_AND: a_nxt = a & rd_data;
      OP_ORA: a_nxt = a | rd_data;
      OP_EOR: a_nxt = a ^ rd_data;
      // Shifts push the lost bit into carry
      OP_ASL: {c_nxt, a_nxt} = {a, 1'b0};
      OP_LSR: {a_nxt, c_nxt} = {1'b0, a};
      OP_CLC: c_nxt = 1'b0;
      OP_SEC: c_nxt = 1'b1;
      default: c_nxt = c;
    endcase
  end

  // Register file, written in the last cycle of the instruction
  always_ff @(posedge clk) begin
    if (!resetn) begin
      a <= '0;
      x <= '0;
      y <= '0;
      c <= 1'b0;
    end else if (seq.commit) begin
      a <= a_nxt;
      x <= x_nxt;
      y <= y_nxt;
      c <= c_nxt;
    end
  end

  // Source register for the three stores
  always_comb begin
    case (instr.op)
      OP_STX:  store_data = x;
      OP_STY:  store_data = y;
      default: store_data = a;
    endcase
  end

endmodule

`default_nettype wire

/* src/instr_latch.sv */
`default_nettype none

module instr_latch import cpu_pkg::*; (
  input  wire        clk,
  input  wire        resetn,
  input  wire byte_t rd_data,
  seq_if.obs         seq,
  instr_if.src       instr
);

  byte_t ir;
  byte_t operand_lo;

  // Opcode byte is on the bus during the fetch cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ir <= NOP_IMP;
    end else if (seq.state == ST_FETCH) begin
      ir <= rd_data;
    end
  end

  // First operand byte, only meaningful for absolute and JMP
  always_ff @(posedge clk) begin
    if (seq.state == ST_DECODE) begin
      operand_lo <= rd_data;
    end
  end

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------
  always_comb begin
    case (ir)
      NOP_IMP, CLC_IMP, SEC_IMP, ASL_ACC, LSR_ACC: instr.mode = MODE_IMP;
      LDA_IMM, LDX_IMM, LDY_IMM:                   instr.mode = MODE_IMM;
      LDA_ABS, LDX_ABS, LDY_ABS,
      STA_ABS, STX_ABS, STY_ABS,
      ADC_ABS, AND_ABS, ORA_ABS, EOR_ABS:          instr.mode = MODE_ABS;
      JMP_ABS:                                     instr.mode = MODE_JMP;
      default:                                     instr.mode = MODE_BAD;
    endcase
  end

  always_comb begin
    case (ir)
      LDA_IMM, LDA_ABS: instr.op = OP_LDA;
      LDX_IMM, LDX_ABS: instr.op = OP_LDX;
      LDY_IMM, LDY_ABS: instr.op = OP_LDY;
      STA_ABS:          instr.op = OP_STA;
      STX_ABS:          instr.op = OP_STX;
      STY_ABS:          instr.op = OP_STY;
      ADC_ABS:          instr.op = OP_ADC;
      AND_ABS:          instr.op = OP_AND;
      ORA_ABS:          instr.op = OP_ORA;
      EOR_ABS:          instr.op = OP_EOR;
      ASL_ACC:          instr.op = OP_ASL;
      LSR_ACC:          instr.op = OP_LSR;
      CLC_IMP:          instr.op = OP_CLC;
      SEC_IMP:          instr.op = OP_SEC;
      JMP_ABS:          instr.op = OP_JMP;
      // NOP and anything undecoded do nothing here
      default:          instr.op = OP_NOP;
    endcase
  end

  assign instr.ir         = ir;
  assign instr.operand_lo = operand_lo;

endmodule

`default_nettype wire

/* verilog.f */
src/cpu_pkg.sv
src/cpu_ifs.sv
src/instr_latch.sv
src/cycle_sequencer.sv
src/exec_unit.sv
src/bus_master.sv
src/cpu_top.sv
bench/tb_memory.sv
bench/tb_cpu_top.sv
